//--- source/fir_config.svh
// --------------------------------------------------
// filter sizes, included by the packages and the RTL
// --------------------------------------------------
`ifndef FIR_CONFIG_SVH
`define FIR_CONFIG_SVH

// number of taps, the coefficients are symmetric
`define FIR_TAPS 16

// mirrored tap pairs, one multiplier each
`define FIR_PAIRS (`FIR_TAPS / 2)

// unsigned input sample
`define FIR_SAMPLE_W 12

// unsigned coefficient, also the multiplier depth
`define FIR_COEF_W 12

// output sum, wide enough for 16 full-scale taps
`define FIR_OUT_W 29

`endif

//--- source/fir_types_pkg.sv
// --------------------------------------------------
// data types passed between the filter stages
// --------------------------------------------------
`default_nettype none

`include "fir_config.svh"

package fir_types_pkg;

    // one input sample
    typedef logic [`FIR_SAMPLE_W-1:0] sample_t;

    // sum of two mirrored samples, one carry bit
    typedef logic [`FIR_SAMPLE_W:0] presum_t;

    // pre-sum times coefficient
    typedef logic [`FIR_SAMPLE_W+`FIR_COEF_W:0] product_t;

    // accumulated output of all eight products
    typedef logic [`FIR_OUT_W-1:0] sum_t;

endpackage

`default_nettype wire

//--- source/fir_coef_pkg.sv
// --------------------------------------------------
// fixed low-pass coefficients, half of the symmetric
// set; tap i and tap 15-i share entry i
// --------------------------------------------------
`default_nettype none

`include "fir_config.svh"

package fir_coef_pkg;

    typedef logic [`FIR_COEF_W-1:0] coef_t;

    // scaled integer coefficients, outer taps first
    localparam coef_t COEFS [`FIR_PAIRS] = '{
        12'd11,
        12'd31,
        12'd63,
        12'd104,
        12'd152,
        12'd198,
        12'd235,
        12'd255
    };

    // gain at DC, every coefficient counted twice
    localparam int unsigned COEF_SUM = 2098;

endpackage

`default_nettype wire

//--- source/fir_preadder.sv
// --------------------------------------------------
// sample delay line and symmetric pre-adder, feeds
// one pre-sum per coefficient pair to the multipliers
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "fir_config.svh"

module fir_preadder (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   en,
    input  fir_types_pkg::sample_t xin,
    output fir_types_pkg::presum_t presum [`FIR_PAIRS],
    output logic                   presum_valid
);

    fir_types_pkg::sample_t taps [`FIR_TAPS]; // taps[0] holds the newest sample
    logic                   en_d;

    // delay line only moves on accepted samples
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `FIR_TAPS; i++) begin
                taps[i] <= '0;
            end
        end else if (en) begin
            taps[0] <= xin;
            for (int i = 1; i < `FIR_TAPS; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

    // strobe follows the sample by one and two cycles
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            en_d         <= 1'b0;
            presum_valid <= 1'b0;
        end else begin
            en_d         <= en;
            presum_valid <= en_d;
        end
    end

    // fold the line: entry i pairs with entry 15-i
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `FIR_PAIRS; i++) begin
                presum[i] <= '0;
            end
        end else if (en_d) begin
            for (int i = 0; i < `FIR_PAIRS; i++) begin
                presum[i] <= fir_types_pkg::presum_t'(taps[i])
                           + fir_types_pkg::presum_t'(taps[`FIR_TAPS-1-i]);
            end
        end
    end

endmodule

`default_nettype wire

//--- source/fir_coef_mult.sv
// --------------------------------------------------
// pipelined shift-and-add multiply by one fixed
// coefficient, one stage per coefficient bit
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "fir_config.svh"

module fir_coef_mult #(
    parameter int COEF_IDX = 0
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    data_rdy,
    input  fir_types_pkg::presum_t  mult1,
    output logic                    res_rdy,
    output fir_types_pkg::product_t res
);

    localparam int STAGES = `FIR_COEF_W;
    localparam fir_coef_pkg::coef_t COEF = fir_coef_pkg::COEFS[COEF_IDX];

    logic                    vld  [STAGES];   // valid bit per stage
    fir_types_pkg::product_t part [STAGES];   // partial product up to bit n
    fir_types_pkg::product_t opnd [STAGES-1]; // operand shifted by n+1

    // one operand per stage, so up to STAGES samples in flight
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int n = 0; n < STAGES; n++) begin
                vld[n]  <= 1'b0;
                part[n] <= '0;
            end
            for (int n = 0; n < STAGES - 1; n++) begin
                opnd[n] <= '0;
            end
        end else begin
            vld[0] <= data_rdy;
            if (data_rdy) begin
                // bit 0 takes the operand unshifted
                part[0] <= COEF[0] ? fir_types_pkg::product_t'(mult1) : '0;
                opnd[0] <= fir_types_pkg::product_t'(mult1) << 1;
            end

            for (int n = 1; n < STAGES; n++) begin
                vld[n] <= vld[n-1];
                if (vld[n-1]) begin
                    part[n] <= COEF[n] ? part[n-1] + opnd[n-1] : part[n-1];
                end
            end

            // last stage needs no further shifted copy
            for (int n = 1; n < STAGES - 1; n++) begin
                if (vld[n-1]) begin
                    opnd[n] <= opnd[n-1] << 1;
                end
            end
        end
    end

    assign res     = part[STAGES-1];
    assign res_rdy = vld[STAGES-1]; // 12 cycles behind data_rdy

endmodule

`default_nettype wire

//--- source/fir_adder_tree.sv
// --------------------------------------------------
// two-level registered sum of the eight products,
// gives the filter output and its strobe
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "fir_config.svh"

module fir_adder_tree (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    in_valid,
    input  fir_types_pkg::product_t products [`FIR_PAIRS],
    output logic                    out_valid,
    output fir_types_pkg::sum_t     sum
);

    localparam int HALF = `FIR_PAIRS / 2;

    fir_types_pkg::sum_t half_lo;  // products 0..3
    fir_types_pkg::sum_t half_hi;  // products 4..7
    fir_types_pkg::sum_t part_lo;
    fir_types_pkg::sum_t part_hi;
    logic                mid_valid;

    always_comb begin
        half_lo = '0;
        half_hi = '0;
        for (int i = 0; i < HALF; i++) begin
            half_lo = half_lo + fir_types_pkg::sum_t'(products[i]);
            half_hi = half_hi + fir_types_pkg::sum_t'(products[i + HALF]);
        end
    end

    // each level loads only behind its own strobe
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            part_lo   <= '0;
            part_hi   <= '0;
            mid_valid <= 1'b0;
            sum       <= '0;
            out_valid <= 1'b0;
        end else begin
            mid_valid <= in_valid;
            out_valid <= mid_valid;
            if (in_valid) begin
                part_lo <= half_lo;
                part_hi <= half_hi;
            end
            if (mid_valid) begin
                sum <= part_lo + part_hi;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/fir_lowpass_top.sv
// --------------------------------------------------
// 16-tap low-pass FIR, strobed samples in, strobed
// sums out 15 cycles later
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "fir_config.svh"

module fir_lowpass_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   en,
    input  fir_types_pkg::sample_t xin,
    output logic                   valid,
    output fir_types_pkg::sum_t    yout
);

    fir_types_pkg::presum_t  presum   [`FIR_PAIRS];
    logic                    presum_valid;
    fir_types_pkg::product_t products [`FIR_PAIRS];
    logic                    mult_rdy [`FIR_PAIRS];

    // delay line and mirrored pre-sums, 2 cycles
    fir_preadder u_preadder (
        .clk          (clk),
        .rstn         (rstn),
        .en           (en),
        .xin          (xin),
        .presum       (presum),
        .presum_valid (presum_valid)
    );

    // one multiplier per tap pair, all 12 stages deep
    genvar k;
    generate
        for (k = 0; k < `FIR_PAIRS; k++) begin : g_mult
            fir_coef_mult #(
                .COEF_IDX (k)
            ) u_mult (
                .clk      (clk),
                .rstn     (rstn),
                .data_rdy (presum_valid),
                .mult1    (presum[k]),
                .res_rdy  (mult_rdy[k]),
                .res      (products[k])
            );
        end
    endgenerate

    // identical latency in every lane, last strobe is enough
    fir_adder_tree u_adder_tree (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (mult_rdy[`FIR_PAIRS-1]),
        .products  (products),
        .out_valid (valid),
        .sum       (yout)
    );

endmodule

`default_nettype wire

//--- verification/fir_tb.sv
// --------------------------------------------------
// testbench for the low-pass FIR, replays the vector
// file twice, with steady and with gapped enable
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "fir_config.svh"

module fir_tb;

    localparam TEST_FILE        = "verification/fir_tests.mem";
    localparam int MAX_TESTS    = 64;
    localparam int LATENCY      = 15;  // en edge to valid edge
    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES  = 8;
    localparam int FULL_SCALE   = (1 << `FIR_SAMPLE_W) - 1;

    logic                   clk;
    logic                   rstn;
    logic                   en;
    fir_types_pkg::sample_t xin;
    logic                   valid;
    fir_types_pkg::sum_t    yout;

    fir_types_pkg::sample_t samples  [MAX_TESTS];
    fir_types_pkg::sum_t    expected [MAX_TESTS];
    int                     n_tests     = 0;
    int                     cyc         = 0;  // rising edges so far
    int                     out_idx     = 0;
    int                     en_cycles [$];    // edge that took each sample
    logic [31:0]            rng;

    fir_lowpass_top uut (
        .clk   (clk),
        .rstn  (rstn),
        .en    (en),
        .xin   (xin),
        .valid (valid),
        .yout  (yout)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // every tap holds a full-scale sample
    function automatic bit full_scale_window(input int idx);
        if (idx < `FIR_TAPS - 1) begin
            return 1'b0;
        end
        for (int j = 0; j < `FIR_TAPS; j++) begin
            if (samples[idx - j] != fir_types_pkg::sample_t'(FULL_SCALE)) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic report_failure();
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_sum(input string name, input fir_types_pkg::sum_t exp_val,
                               input fir_types_pkg::sum_t act_val);
        if (act_val !== exp_val) begin
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d",
                     $time, name, exp_val, act_val);
            report_failure();
        end
    endtask

    task automatic compare_valid(input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("CHECK FAILED at %0t: valid expected %b, got %b",
                     $time, exp_val, act_val);
            report_failure();
        end
    endtask

    task automatic compare_latency(input int exp_val, input int act_val);
        if (act_val != exp_val) begin
            $display("CHECK FAILED at %0t: valid latency expected %0d cycles, got %0d",
                     $time, exp_val, act_val);
            report_failure();
        end
    endtask

    // decimal pairs, lines that do not scan as two numbers are comments
    task automatic load_tests();
        int    fd;
        int    code;
        int    got;
        int    s_val;
        int    y_val;
        string line;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("could not open the test vector file %s", TEST_FILE);
            report_failure();
        end else begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                code = $fgets(line, fd);
                if (code > 0) begin
                    got = $sscanf(line, "%d %d", s_val, y_val);
                    if (got == 2) begin
                        samples[n_tests]  = fir_types_pkg::sample_t'(s_val);
                        expected[n_tests] = fir_types_pkg::sum_t'(y_val);
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
            if (n_tests == 0) begin
                $display("the test vector file holds no samples");
                report_failure();
            end
        end
    endtask

    task automatic apply_reset();
        rstn = 1'b0;
        en   = 1'b0;
        xin  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;
    endtask

    // nothing may come out before the first sample
    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            compare_valid(1'b0, valid);
            compare_sum("yout", '0, yout);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic run_pass(input bit gapped);
        int i;
        apply_reset();
        out_idx = 0;
        check_idle(IDLE_CYCLES);
        i = 0;
        while (i < n_tests) begin
            if (gapped) rng = xorshift32(rng);
            if (!gapped || rng[0]) begin
                en  = 1'b1;
                xin = samples[i];
                en_cycles.push_back(cyc + 1); // taken at the coming edge
                i++;
            end else begin
                en  = 1'b0;
                xin = rng[23:12]; // junk, must be ignored
            end
            @(posedge clk);
            #1;
        end
        en  = 1'b0;
        xin = '0;
        wait (out_idx == n_tests);
        // quiet time, a late or doubled strobe shows up here
        repeat (2 * LATENCY) @(posedge clk);
        #1;
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rstn && valid) begin
            if (en_cycles.size() == 0) begin
                $display("valid went high at %0t with no accepted sample pending", $time);
                report_failure();
            end else begin
                compare_latency(LATENCY, cyc - en_cycles.pop_front());
                compare_sum("yout", expected[out_idx], yout);
                if (full_scale_window(out_idx)) begin
                    compare_sum("yout at full-scale DC",
                                fir_types_pkg::sum_t'(FULL_SCALE * fir_coef_pkg::COEF_SUM),
                                yout);
                end
                out_idx++;
            end
        end
    end

    // two passes over the file, four cycles per sample is ample
    initial begin
        int limit;
        wait (n_tests > 0);
        limit = 2 * n_tests * 4 + 100;
        repeat (limit) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", limit);
        report_failure();
    end

    initial begin
        rstn = 1'b0;
        en   = 1'b0;
        xin  = '0;
        rng  = 32'd36116;
        load_tests();
        run_pass(1'b0); // en high for every sample
        run_pass(1'b1); // random gaps between samples
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/fir_tests.mem
// columns: input sample, expected filter output, both decimal
// one accepted sample per line, outputs come back in this order
// impulse, the outputs walk through all 16 taps
1 11
0 31
0 63
0 104
0 152
0 198
0 235
0 255
0 255
0 235
0 198
0 152
0 104
0 63
0 31
0 11
0 0
// full scale DC, ramps up to 4095 x 2098
4095 45045
4095 171990
4095 429975
4095 855855
4095 1478295
4095 2289105
4095 3251430
4095 4295655
4095 5339880
4095 6302205
4095 7113015
4095 7735455
4095 8161335
4095 8419320
4095 8546265
4095 8591310
4095 8591310
// arbitrary samples entering on top of the DC history
1234 8559839
87 8458531
3901 8284685
512 7995835
2750 7601516

//--- list.f
+incdir+source
source/fir_types_pkg.sv
source/fir_coef_pkg.sv
source/fir_preadder.sv
source/fir_coef_mult.sv
source/fir_adder_tree.sv
source/fir_lowpass_top.sv
verification/fir_tb.sv

//--- Makefile
SIM        := verilator
TOP        := fir_tb
RTL_TOP    := fir_lowpass_top
FILELIST   := list.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing -j 0
LINT_FLAGS := --lint-only -Wall --timing
PASS_MSG   := ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
